// File: src/mems_pkg.sv
package mems_pkg;

  // command nibble, top 4 bits of every DAC word
  typedef enum logic [3:0] {
    CMD_WRITE_CHAN       = 4'h1,  // write input register n only
    CMD_WRITE_UPDATE_ALL = 4'h2,  // write input register n, update all outputs
    CMD_SW_RESET         = 4'h6,
    CMD_REF_SETUP        = 4'h7
  } dac_cmd_t;

  typedef enum logic [3:0] {
    CHAN_A   = 4'b0001,  // mirror x axis
    CHAN_B   = 4'b0010,  // mirror y axis
    CHAN_ALL = 4'b1111
  } dac_chan_t;

  // shifted out msb first
  typedef struct packed {
    dac_cmd_t    cmd;
    dac_chan_t   chan;
    logic [15:0] data;
  } dac_frame_t;

  typedef enum logic [1:0] {
    STEP_RESET,
    STEP_VREF,
    STEP_X,
    STEP_Y
  } step_kind_t;

  typedef struct packed {
    step_kind_t  kind;
    logic [15:0] col;
    logic [15:0] row;
    logic [15:0] frame_idx;
  } scan_step_t;

  typedef struct packed {
    logic [15:0] line_idx;   // row within the frame
    logic [15:0] frame_idx;
  } line_info_t;

  typedef struct packed {
    logic [15:0] frame_idx;  // frame just finished
  } frame_info_t;

  localparam logic [15:0] VREF_DATA = 16'h0001;  // internal ref off, REFIN pin used

  localparam logic [15:0] DEF_POINTS_PER_LINE = 16'd64;
  localparam logic [15:0] DEF_LINES_PER_FRAME = 16'd64;
  localparam logic [15:0] DEF_X_STEP          = 16'd1024;
  localparam logic [15:0] DEF_Y_STEP          = 16'd1024;
  localparam logic [15:0] DEF_SCLK_DIV        = 16'd4;

endpackage

// File: src/mems_dac_decode.sv
`timescale 1ns/1ps

module mems_dac_decode #(
  parameter logic [15:0] POINTS_PER_LINE = mems_pkg::DEF_POINTS_PER_LINE,
  parameter logic [15:0] LINES_PER_FRAME = mems_pkg::DEF_LINES_PER_FRAME,
  parameter logic [15:0] X_STEP          = mems_pkg::DEF_X_STEP,
  parameter logic [15:0] Y_STEP          = mems_pkg::DEF_Y_STEP
) (
  input  mems_pkg::scan_step_t step,
  output mems_pkg::dac_frame_t frame,
  output logic                 line_end,
  output logic                 frame_end
);
  import mems_pkg::*;

  logic [31:0] x_prod;
  logic [31:0] y_prod;
  logic        is_y;
  logic        last_col;
  logic        last_row;

  // full products, only the low half reaches the dac
  assign x_prod = 32'(step.col) * 32'(X_STEP);
  assign y_prod = 32'(step.row) * 32'(Y_STEP);

  assign is_y     = (step.kind == STEP_Y);
  assign last_col = (step.col == POINTS_PER_LINE - 16'd1);
  assign last_row = (step.row == LINES_PER_FRAME - 16'd1);

  // only the y word completes a point
  assign line_end  = is_y && last_col;
  assign frame_end = is_y && last_col && last_row;

  always_comb begin
    unique case (step.kind)
      STEP_RESET: begin
        frame = '{cmd: CMD_SW_RESET, chan: CHAN_ALL, data: 16'h0000};
      end
      STEP_VREF: begin
        frame = '{cmd: CMD_REF_SETUP, chan: CHAN_ALL, data: VREF_DATA};
      end
      STEP_X: begin
        // load A, output holds until the y word
        frame = '{cmd: CMD_WRITE_CHAN, chan: CHAN_A, data: x_prod[15:0]};
      end
      STEP_Y: begin
        // load B and move both axes together
        frame = '{cmd: CMD_WRITE_UPDATE_ALL, chan: CHAN_B, data: y_prod[15:0]};
      end
    endcase
  end

endmodule

// File: src/mems_spi_tx.sv
`timescale 1ns/1ps

module mems_spi_tx #(
  parameter logic [15:0] SCLK_DIV = mems_pkg::DEF_SCLK_DIV
) (
  input  logic                 clk,
  input  logic                 mems_soft_reset,
  input  logic                 start,
  input  mems_pkg::dac_frame_t frame,
  output logic                 busy,
  output logic                 sclk,
  output logic                 mosi,
  output logic                 sync_n
);
  import mems_pkg::*;

  localparam int FRAME_W = $bits(dac_frame_t);

  // half periods are numbered from 0, the last one is the low phase after bit 24 falls
  localparam logic [5:0] LAST_HALF = 6'(2 * FRAME_W - 1);

  logic [15:0]        div_cnt;   // clocks within a half period
  logic [5:0]         half_cnt;
  logic [FRAME_W-1:0] shreg;
  logic               half_done;
  logic               rise;      // next sclk edge is a rising one

  assign half_done = (div_cnt == SCLK_DIV - 16'd1);
  assign rise      = half_done && half_cnt[0] && (half_cnt != LAST_HALF);

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy     <= 1'b0;
      sync_n   <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else if (!busy) begin
      div_cnt  <= '0;
      half_cnt <= '0;
      if (start) begin
        busy   <= 1'b1;
        sync_n <= 1'b0;
        sclk   <= 1'b1;                // first rising edge with sync_n fall
        mosi   <= frame[FRAME_W-1];
      end
    end else if (half_done) begin
      div_cnt  <= '0;
      half_cnt <= half_cnt + 6'd1;
      if (!half_cnt[0]) begin
        sclk <= 1'b0;                  // dac samples here
      end else if (half_cnt == LAST_HALF) begin
        busy   <= 1'b0;
        sync_n <= 1'b1;
      end else begin
        sclk <= 1'b1;
        mosi <= shreg[FRAME_W-1];
      end
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  // holds the bits still to go, msb aligned
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shreg <= {frame[FRAME_W-2:0], 1'b0};
    end else if (busy && rise) begin
      shreg <= {shreg[FRAME_W-2:0], 1'b0};
    end
  end

endmodule

// File: src/mems_marker_hs.sv
`timescale 1ns/1ps

module mems_marker_hs #(
  parameter type payload_t = logic [15:0]
) (
  input  logic     clk,
  input  logic     mems_soft_reset,
  input  logic     push,
  input  payload_t payload_in,
  output logic     ready,
  output logic     req,
  input  logic     ack,
  output payload_t payload
);

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_REQ,      // req high until ack is seen
    HS_RELEASE   // req low until ack drops
  } hs_state_t;

  hs_state_t state_q;

  assign ready = (state_q == HS_IDLE);
  assign req   = (state_q == HS_REQ);

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state_q <= HS_IDLE;
    end else begin
      unique case (state_q)
        HS_IDLE: begin
          if (push) begin
            state_q <= HS_REQ;
          end
        end
        HS_REQ: begin
          if (ack) begin
            state_q <= HS_RELEASE;
          end
        end
        HS_RELEASE: begin
          if (!ack) begin
            state_q <= HS_IDLE;   // slot free again
          end
        end
        default: state_q <= HS_IDLE;
      endcase
    end
  end

  // captured once per marker and held through the whole handshake
  always_ff @(posedge clk) begin
    if (push) begin
      payload <= payload_in;
    end
  end

endmodule

// File: src/mems_scan_seq.sv
`timescale 1ns/1ps

module mems_scan_seq #(
  parameter logic [15:0] POINTS_PER_LINE = mems_pkg::DEF_POINTS_PER_LINE,
  parameter logic [15:0] LINES_PER_FRAME = mems_pkg::DEF_LINES_PER_FRAME
) (
  input  logic                  clk,
  input  logic                  mems_soft_reset,
  input  logic                  pause,
  input  logic                  busy,
  input  logic                  line_ready,
  input  logic                  frame_ready,
  input  logic                  line_end,
  input  logic                  frame_end,
  output mems_pkg::scan_step_t  step,
  output logic                  start,
  output logic                  line_push,
  output logic                  frame_push,
  output mems_pkg::line_info_t  line_info,
  output mems_pkg::frame_info_t frame_info
);
  import mems_pkg::*;

  step_kind_t  state_q;  // kind of the next word to send
  logic [15:0] col_q;
  logic [15:0] row_q;
  logic [15:0] frame_q;

  logic last_col;
  logic last_row;
  logic markers_ok;
  logic launch;

  assign step = '{kind: state_q, col: col_q, row: row_q, frame_idx: frame_q};

  assign last_col = (col_q == POINTS_PER_LINE - 16'd1);
  assign last_row = (row_q == LINES_PER_FRAME - 16'd1);

  // a word that ends a line or frame needs a free marker slot first
  assign markers_ok = (!line_end || line_ready) && (!frame_end || frame_ready);

  // spi idle and our own start already gone
  assign launch = !busy && !start && !pause && markers_ok;

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      start <= 1'b0;
    end else begin
      start <= launch;  // single cycle, launch needs start low
    end
  end

  // step moves on while start is high, decode stays valid for the spi latch
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state_q <= STEP_RESET;
      col_q   <= '0;
      row_q   <= '0;
      frame_q <= '0;
    end else if (start) begin
      unique case (state_q)
        STEP_RESET: state_q <= STEP_VREF;
        STEP_VREF:  state_q <= STEP_X;  // setup done, never revisited
        STEP_X:     state_q <= STEP_Y;
        STEP_Y: begin
          state_q <= STEP_X;
          if (!last_col) begin
            col_q <= col_q + 16'd1;
          end else begin
            col_q <= '0;
            if (!last_row) begin
              row_q <= row_q + 16'd1;
            end else begin
              row_q   <= '0;  // raster wraps
              frame_q <= frame_q + 16'd1;
            end
          end
        end
      endcase
    end
  end

  // push one cycle after the completing y start
  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      line_push  <= 1'b0;
      frame_push <= 1'b0;
    end else begin
      line_push  <= start && line_end;
      frame_push <= start && frame_end;
    end
  end

  always_ff @(posedge clk) begin
    if (start && line_end) begin
      line_info <= '{line_idx: row_q, frame_idx: frame_q};
    end
    if (start && frame_end) begin
      frame_info <= '{frame_idx: frame_q};
    end
  end

endmodule

// File: src/mems_top.sv
`timescale 1ns/1ps

module mems_top #(
  parameter logic [15:0] POINTS_PER_LINE = mems_pkg::DEF_POINTS_PER_LINE,
  parameter logic [15:0] LINES_PER_FRAME = mems_pkg::DEF_LINES_PER_FRAME,
  parameter logic [15:0] X_STEP          = mems_pkg::DEF_X_STEP,
  parameter logic [15:0] Y_STEP          = mems_pkg::DEF_Y_STEP,
  parameter logic [15:0] SCLK_DIV        = mems_pkg::DEF_SCLK_DIV
) (
  input  logic                  clk,
  input  logic                  mems_soft_reset,
  input  logic                  pause,
  output logic                  sclk,
  output logic                  mosi,
  output logic                  sync_n,
  output logic                  line_req,
  input  logic                  line_ack,
  output mems_pkg::line_info_t  line_info,
  output logic                  frame_req,
  input  logic                  frame_ack,
  output mems_pkg::frame_info_t frame_info
);
  import mems_pkg::*;

  scan_step_t  step;
  dac_frame_t  dac_frame;
  line_info_t  seq_line_info;
  frame_info_t seq_frame_info;

  logic start;
  logic busy;
  logic line_end;
  logic frame_end;
  logic line_ready;
  logic frame_ready;
  logic line_push;
  logic frame_push;

  mems_scan_seq #(
    .POINTS_PER_LINE(POINTS_PER_LINE),
    .LINES_PER_FRAME(LINES_PER_FRAME)
  ) seq_i (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .pause(pause), .busy(busy),
    .line_ready(line_ready), .frame_ready(frame_ready),
    .line_end(line_end), .frame_end(frame_end),
    .step(step), .start(start), .line_push(line_push), .frame_push(frame_push),
    .line_info(seq_line_info), .frame_info(seq_frame_info)
  );

  mems_dac_decode #(
    .POINTS_PER_LINE(POINTS_PER_LINE), .LINES_PER_FRAME(LINES_PER_FRAME),
    .X_STEP(X_STEP), .Y_STEP(Y_STEP)
  ) decode_i (
    .step(step), .frame(dac_frame), .line_end(line_end), .frame_end(frame_end)
  );

  mems_spi_tx #(.SCLK_DIV(SCLK_DIV)) spi_i (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .start(start), .frame(dac_frame),
    .busy(busy), .sclk(sclk), .mosi(mosi), .sync_n(sync_n)
  );

  mems_marker_hs #(.payload_t(line_info_t)) line_hs_i (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .push(line_push),
    .payload_in(seq_line_info), .ready(line_ready),
    .req(line_req), .ack(line_ack), .payload(line_info)
  );

  mems_marker_hs #(.payload_t(frame_info_t)) frame_hs_i (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .push(frame_push),
    .payload_in(seq_frame_info), .ready(frame_ready),
    .req(frame_req), .ack(frame_ack), .payload(frame_info)
  );

endmodule

// File: bench/mems_top_chk.sv
`timescale 1ns/1ps

module mems_top_chk (
  input logic                  clk,
  input logic                  mems_soft_reset,
  input logic                  sclk,
  input logic                  mosi,
  input logic                  sync_n,
  input logic                  line_req,
  input logic                  line_ack,
  input mems_pkg::line_info_t  line_info,
  input logic                  frame_req,
  input logic                  frame_ack,
  input mems_pkg::frame_info_t frame_info
);

  // req only drops once ack was seen
  line_req_hold: assert property (@(posedge clk) disable iff (mems_soft_reset)
    line_req && !line_ack |=> line_req)
    else $error("line_req dropped before line_ack");

  frame_req_hold: assert property (@(posedge clk) disable iff (mems_soft_reset)
    frame_req && !frame_ack |=> frame_req)
    else $error("frame_req dropped before frame_ack");

  line_payload_stable: assert property (@(posedge clk) disable iff (mems_soft_reset)
    line_req |=> !line_req || $stable(line_info))
    else $error("line_info changed while line_req high");

  frame_payload_stable: assert property (@(posedge clk) disable iff (mems_soft_reset)
    frame_req |=> !frame_req || $stable(frame_info))
    else $error("frame_info changed while frame_req high");

  // dac samples on the falling edge
  mosi_stable: assert property (@(posedge clk) disable iff (mems_soft_reset)
    sclk && $past(sclk) |-> $stable(mosi))
    else $error("mosi moved while sclk high");

  reset_values: assert property (@(posedge clk)
    $past(mems_soft_reset) |-> sync_n && !sclk && !line_req && !frame_req)
    else $error("outputs not idle after reset");

endmodule

bind mems_top mems_top_chk chk_i (
  .clk(clk), .mems_soft_reset(mems_soft_reset), .sclk(sclk), .mosi(mosi),
  .sync_n(sync_n), .line_req(line_req), .line_ack(line_ack), .line_info(line_info),
  .frame_req(frame_req), .frame_ack(frame_ack), .frame_info(frame_info)
);

// File: bench/mems_tb.sv
`timescale 1ns/1ps

module mems_tb;
  import mems_pkg::*;

  localparam int POINTS = 4;
  localparam int LINES  = 3;
  localparam int X_STEP = 'h1000;
  localparam int Y_STEP = 'h2000;

  logic        clk = 1'b0;
  logic        mems_soft_reset = 1'b1;
  logic        pause = 1'b0;
  logic        line_ack = 1'b0;
  logic        frame_ack = 1'b0;
  logic        sclk, mosi, sync_n, line_req, frame_req;
  line_info_t  line_info;
  frame_info_t frame_info;

  int errors = 0, starts = 0, words_done = 0, nbits = 0, ack_delay = 0;
  int line_rx = 0, frame_rx = 0, line_done = 0, frame_done = 0;
  int line_wait = 0, frame_wait = 0;
  logic        line_seen = 1'b0, frame_seen = 1'b0, aborted = 1'b0;
  logic [23:0] shift = '0;
  logic [31:0] lfsr = 32'h55569078;

  mems_top #(
    .POINTS_PER_LINE(16'(POINTS)), .LINES_PER_FRAME(16'(LINES)),
    .X_STEP(16'(X_STEP)), .Y_STEP(16'(Y_STEP)), .SCLK_DIV(16'd2)
  ) dut_i (
    .clk(clk), .mems_soft_reset(mems_soft_reset), .pause(pause),
    .sclk(sclk), .mosi(mosi), .sync_n(sync_n),
    .line_req(line_req), .line_ack(line_ack), .line_info(line_info),
    .frame_req(frame_req), .frame_ack(frame_ack), .frame_info(frame_info)
  );

  always #2 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int ack_wait_cycles();
    int j;
    lfsr = lfsr_next(lfsr);
    j = lfsr[0] ? 1 : 0;
    lfsr = lfsr_next(lfsr);
    j = j + (lfsr[0] ? 2 : 0);
    return ack_delay + j;
  endfunction

  // word 0 reset, word 1 vref, then x and y per point in raster order
  function automatic logic [23:0] expected_word(input int w);
    int p;
    int col;
    int row;
    if (w == 0) return {CMD_SW_RESET, CHAN_ALL, 16'h0000};
    if (w == 1) return {CMD_REF_SETUP, CHAN_ALL, VREF_DATA};
    p   = (w - 2) / 2;
    col = p % POINTS;
    row = (p / POINTS) % LINES;
    if ((w - 2) % 2 == 0) return {CMD_WRITE_CHAN, CHAN_A, 16'(col * X_STEP)};
    return {CMD_WRITE_UPDATE_ALL, CHAN_B, 16'(row * Y_STEP)};
  endfunction

  // global line that a word completes or -1
  function automatic int line_of_word(input int w);
    if (w < 2 || (w - 2) % 2 == 0) return -1;
    if (((w - 2) / 2) % POINTS != POINTS - 1) return -1;
    return ((w - 2) / 2) / POINTS;
  endfunction

  always @(negedge sync_n) begin
    int k;
    k = line_of_word(starts);
    if (k >= 0) begin
      assert (line_done == k) else begin
        $display("word %0d started before line marker %0d was acknowledged", starts, k - 1);
        errors++;
      end
      if (k % LINES == LINES - 1) begin
        assert (frame_done == k / LINES) else begin
          $display("word %0d started before the previous frame marker finished", starts);
          errors++;
        end
      end
    end
    starts++;
    nbits = 0;
  end

  always @(negedge sclk) begin
    if (!sync_n) begin
      shift = {shift[22:0], mosi};
      nbits++;
    end
  end

  always @(posedge sync_n) begin
    if (starts > words_done) begin
      assert (nbits == 24) else begin
        $display("[ERROR] sclk falls in word %0d: got %0h expected %0h", words_done, nbits, 24);
        errors++;
      end
      assert (shift == expected_word(words_done)) else begin
        $display("[ERROR] mosi word %0d: got %06h expected %06h", words_done, shift,
                 expected_word(words_done));
        errors++;
      end
      words_done++;
    end
  end

  // marker responders ack after the delay plus 0..3 cycles
  always @(negedge clk) begin
    if (!mems_soft_reset) begin
      if (!line_req) begin
        line_seen = 1'b0;
      end else if (!line_seen) begin
        line_seen = 1'b1;
        assert (line_info == {16'(line_rx % LINES), 16'(line_rx / LINES)}) else begin
          $display("[ERROR] line_info marker %0d: got %08h expected %08h", line_rx, line_info,
                   {16'(line_rx % LINES), 16'(line_rx / LINES)});
          errors++;
        end
        assert (starts > 2 * line_rx * POINTS + 2 * POINTS + 1) else begin
          $display("line marker %0d raised before its last word started", line_rx);
          errors++;
        end
        line_rx++;
        line_wait = ack_wait_cycles();
      end
      if (line_ack && !line_req) begin
        line_ack = 1'b0;
        line_done++;
      end else if (!line_ack && line_seen) begin
        if (line_wait == 0) line_ack = 1'b1;
        else line_wait--;
      end
      if (!frame_req) begin
        frame_seen = 1'b0;
      end else if (!frame_seen) begin
        frame_seen = 1'b1;
        assert (frame_info == 16'(frame_rx)) else begin
          $display("[ERROR] frame_info marker %0d: got %04h expected %04h", frame_rx,
                   frame_info, 16'(frame_rx));
          errors++;
        end
        assert (starts > 2 * ((frame_rx + 1) * LINES - 1) * POINTS + 2 * POINTS + 1) else begin
          $display("frame marker %0d raised before its last word started", frame_rx);
          errors++;
        end
        frame_rx++;
        frame_wait = ack_wait_cycles();
      end
      if (frame_ack && !frame_req) begin
        frame_ack = 1'b0;
        frame_done++;
      end else if (!frame_ack && frame_seen) begin
        if (frame_wait == 0) frame_ack = 1'b1;
        else frame_wait--;
      end
    end
  end

  task automatic wait_words(input int target, input int limit);
    int t;
    t = 0;
    while (words_done < target && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (words_done < target) begin
      $display("timeout waiting for word %0d, only %0d words arrived", target, words_done);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_frame_marker(input int target, input int limit);
    int t;
    t = 0;
    while (frame_rx < target && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (frame_rx < target) begin
      $display("timeout waiting for frame marker %0d", target - 1);
      errors++;
      aborted = 1'b1;
    end
  endtask

  initial begin
    int fd;
    int r;
    int val;
    int points;
    int snap;
    logic [8*8-1:0]   kind;
    logic [8*160-1:0] rest;
    points = 0;
    repeat (2) @(negedge clk);
    mems_soft_reset = 1'b0;
    fd = $fopen("bench/mems_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/mems_tests.txt");
      errors++;
      aborted = 1'b1;
    end
    while (!aborted && $fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        r = $fgets(rest, fd);  // skip comment text
      end else begin
        r = $fscanf(fd, "%d", val);
        if (r != 1) begin
          $display("a record in the test file has no value");
          errors++;
          aborted = 1'b1;
        end else if (kind == "run") begin
          points += val;
          wait_words(2 + 2 * points, 2000 + 2 * val * (150 + ack_delay));
        end else if (kind == "pause") begin
          wait_frame_marker(frame_rx + 1, 2000 + 24 * (150 + ack_delay));
          if (!aborted) begin
            pause = 1'b1;
            @(negedge clk);  // a start already issued may still go out
            snap = starts;
            repeat (val) @(negedge clk);
            assert (starts == snap) else begin
              $display("%0d words started while pause was high", starts - snap);
              errors++;
            end
            pause = 1'b0;
          end
        end else if (kind == "ack") begin
          ack_delay = val;
        end else if (kind == "lines") begin
          assert (line_rx == val) else begin
            $display("[ERROR] line_req count: got %0h expected %0h", line_rx, val);
            errors++;
          end
        end else if (kind == "frames") begin
          assert (frame_rx == val) else begin
            $display("[ERROR] frame_req count: got %0h expected %0h", frame_rx, val);
            errors++;
          end
        end else begin
          $display("unknown record kind in the test file");
          errors++;
          aborted = 1'b1;
        end
      end
    end
    if (fd != 0) $fclose(fd);
    $display("words %0d, line markers %0d, frame markers %0d, errors %0d",
             words_done, line_rx, frame_rx, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
src/mems_pkg.sv
src/mems_dac_decode.sv
src/mems_spi_tx.sv
src/mems_marker_hs.sv
src/mems_scan_seq.sv
src/mems_top.sv
bench/mems_top_chk.sv
bench/mems_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mems scan controller testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mems_tb -f sources.f -o mems_sim

./obj_dir/mems_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: bench/mems_tests.txt
# each record is a kind word followed by a decimal value
# run points, pause cycles at next frame marker, ack delay, lines and frames expected so far
ack 1
run 12
lines 3
frames 1
run 14
lines 6
frames 2
pause 300
run 16
lines 10
frames 3
ack 1000
run 16
lines 14
frames 4
ack 0
run 14
lines 18
frames 6
